// ==== include/ur_consts.svh ====
/*
 * Unsupported Request responder constants
 * Header and dword widths, format and type codes of the request
 * header, field positions in dword 0 and the fixed completion values.
 */
`ifndef UR_CONSTS_SVH
`define UR_CONSTS_SVH

// --------------------------------------------------
// Widths
// --------------------------------------------------
`define UR_HDR_W            128
`define UR_DW_W             32

// Field positions in dword 0
`define UR_FMT_MSB          31
`define UR_FMT_LSB          29
`define UR_TYPE_MSB         28
`define UR_TYPE_LSB         24

// --------------------------------------------------
// Request format and type codes
// --------------------------------------------------
`define UR_FMT_3DW_RD       3'b000
`define UR_FMT_4DW_RD       3'b001
`define UR_FMT_3DW_WR       3'b010
`define UR_FMT_4DW_WR       3'b011
`define UR_TYPE_MEM         5'b00000
// Top two type bits of Msg and MsgD
`define UR_TYPE_MSG_PREFIX  2'b10

// --------------------------------------------------
// Completion fields
// --------------------------------------------------
`define UR_CPL_FMT          3'b000
`define UR_CPL_TYPE         5'b01010
// Unsupported Request
`define UR_CPL_STATUS       3'b001
`define UR_DEFAULT_BYTE_CNT 12'd4

`endif

// ==== logic/ur_pkg.sv ====
/*
 * Unsupported Request responder types
 * Plain vector types for the packet header, its dwords and the
 * fields that are carried from a request into its completion.
 */
`include "ur_consts.svh"

package ur_pkg;

  // --------------------------------------------------
  // Header containers
  // --------------------------------------------------
  // Four dwords with dword 0 in the low bits
  typedef logic [`UR_HDR_W-1:0] hdr_t;
  typedef logic [`UR_DW_W-1:0]  dword_t;

  // Header fields of dword 0
  typedef logic [2:0]           fmt_t;
  typedef logic [4:0]           pkt_type_t;

  // --------------------------------------------------
  // Identity and configuration
  // --------------------------------------------------
  typedef logic [7:0]           bus_num_t;
  typedef logic [4:0]           dev_num_t;
  // Bus, device and function packed together
  typedef logic [15:0]          req_id_t;

  // --------------------------------------------------
  // Completion fields
  // --------------------------------------------------
  // Extended tag whose two high bits live in dword 0
  typedef logic [9:0]           tag_t;
  typedef logic [11:0]          byte_cnt_t;
  typedef logic [6:0]           lower_addr_t;

endpackage

// ==== logic/ur_rx_stage.sv ====
/*
 * Receive stage of the Unsupported Request responder
 * Sorts each incoming header by format and type. Posted packets
 * (memory writes, Msg, MsgD) are dropped, all others are captured
 * in one register stage together with their strobes and a flag
 * that marks memory reads. Also holds the receive-ready level.
 */
`timescale 1ns/1ps
`include "ur_consts.svh"

module ur_rx_stage (
  input  logic         clk,
  input  logic         rst_n,
  input  ur_pkg::hdr_t rx_header_i,
  input  logic         rx_sop_i,
  input  logic         rx_eop_i,
  input  logic         rx_valid_i,
  output ur_pkg::hdr_t req_hdr_o,
  output logic         req_sop_o,
  output logic         req_valid_o,
  output logic         req_eop_o,
  output logic         req_is_mem_rd_o,
  output logic         rx_ready_o
);

  ur_pkg::dword_t    rx_dw0;
  ur_pkg::fmt_t      rx_fmt;
  ur_pkg::pkt_type_t rx_type;
  logic              is_mem_type;
  logic              is_msg_type;
  logic              is_mem_wr;
  logic              is_msg;
  logic              is_msg_data;
  logic              is_mem_rd;
  logic              drop_pkt;

  // --------------------------------------------------
  // Header decode
  // --------------------------------------------------
  assign rx_dw0  = rx_header_i[`UR_DW_W-1:0];
  assign rx_fmt  = rx_dw0[`UR_FMT_MSB:`UR_FMT_LSB];
  assign rx_type = rx_dw0[`UR_TYPE_MSB:`UR_TYPE_LSB];

  assign is_mem_type = (rx_type == `UR_TYPE_MEM);
  assign is_msg_type = (rx_type[4:3] == `UR_TYPE_MSG_PREFIX);

  // Posted requests never get a completion
  assign is_mem_wr   = is_mem_type &&
                       ((rx_fmt == `UR_FMT_3DW_WR) || (rx_fmt == `UR_FMT_4DW_WR));
  assign is_msg      = is_msg_type && (rx_fmt == `UR_FMT_4DW_RD);
  assign is_msg_data = is_msg_type && (rx_fmt == `UR_FMT_4DW_WR);
  assign drop_pkt    = is_mem_wr || is_msg || is_msg_data;

  // Memory read in 3DW or 4DW format
  assign is_mem_rd   = is_mem_type &&
                       ((rx_fmt == `UR_FMT_3DW_RD) || (rx_fmt == `UR_FMT_4DW_RD));

  // --------------------------------------------------
  // Request register
  // --------------------------------------------------
  // Strobes and flags
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_sop_o       <= 1'b0;
      req_eop_o       <= 1'b0;
      req_valid_o     <= 1'b0;
      req_is_mem_rd_o <= 1'b0;
      rx_ready_o      <= 1'b0;
    end
    else
    begin
      req_sop_o       <= drop_pkt ? 1'b0 : rx_sop_i;
      req_eop_o       <= drop_pkt ? 1'b0 : rx_eop_i;
      req_valid_o     <= drop_pkt ? 1'b0 : rx_valid_i;
      req_is_mem_rd_o <= is_mem_rd;
      // Always ready once out of reset
      rx_ready_o      <= 1'b1;
    end
  end

  // Header payload is masked downstream while not valid
  always_ff @(posedge clk)
  begin
    req_hdr_o <= drop_pkt ? '0 : rx_header_i;
  end

endmodule

// ==== logic/ur_header_build.sv ====
/*
 * Completion header builder
 * Turns a registered request header into a four-dword Unsupported
 * Request completion header. Copies requester ID, tag, traffic class
 * and attributes, forms the completer ID from the configured bus and
 * device numbers and computes byte count and lower address.
 * Purely combinational.
 */
`timescale 1ns/1ps
`include "ur_consts.svh"

module ur_header_build (
  input  ur_pkg::hdr_t     req_hdr_i,
  input  logic             req_sop_i,
  input  logic             req_eop_i,
  input  logic             req_valid_i,
  input  logic             req_is_mem_rd_i,
  input  ur_pkg::bus_num_t bus_num_i,
  input  ur_pkg::dev_num_t dev_num_i,
  output ur_pkg::hdr_t     tx_header_o,
  output logic             tx_sop_o,
  output logic             tx_eop_o,
  output logic             tx_valid_o
);

  ur_pkg::dword_t      req_dw0;
  ur_pkg::dword_t      req_dw1;
  ur_pkg::dword_t      req_dw2;
  ur_pkg::dword_t      req_dw3;
  ur_pkg::tag_t        tag;
  logic [2:0]          tc;
  logic [2:0]          attr;
  ur_pkg::req_id_t     requester_id;
  ur_pkg::req_id_t     completer_id;
  ur_pkg::byte_cnt_t   byte_cnt;
  ur_pkg::lower_addr_t lower_addr;
  ur_pkg::dword_t      cpl_dw0;
  ur_pkg::dword_t      cpl_dw1;
  ur_pkg::dword_t      cpl_dw2;
  ur_pkg::dword_t      cpl_dw3;
  ur_pkg::hdr_t        cpl_hdr;

  // --------------------------------------------------
  // Request fields
  // --------------------------------------------------
  assign req_dw0 = req_hdr_i[1*`UR_DW_W-1:0*`UR_DW_W];
  assign req_dw1 = req_hdr_i[2*`UR_DW_W-1:1*`UR_DW_W];
  assign req_dw2 = req_hdr_i[3*`UR_DW_W-1:2*`UR_DW_W];
  assign req_dw3 = req_hdr_i[4*`UR_DW_W-1:3*`UR_DW_W];

  // Tag bits 9 and 8 sit in dword 0, the rest in dword 1
  assign tag          = {req_dw0[23], req_dw0[19], req_dw1[15:8]};
  assign attr         = {req_dw0[18], req_dw0[13:12]};
  assign tc           = req_dw0[22:20];
  assign requester_id = req_dw1[31:16];

  // Function number is always 0
  assign completer_id = {bus_num_i, dev_num_i, 3'b000};

  // Memory reads report the full request size in bytes
  assign byte_cnt = req_is_mem_rd_i ? {req_dw0[9:0], 2'b00} : `UR_DEFAULT_BYTE_CNT;

  // Lower address only for memory reads and taken from the address dword
  always_comb
  begin
    case (req_dw0[31:24])
      {`UR_FMT_3DW_RD, `UR_TYPE_MEM}: lower_addr = {req_dw2[6:2], 2'b00};
      {`UR_FMT_4DW_RD, `UR_TYPE_MEM}: lower_addr = {req_dw3[6:2], 2'b00};
      default:                        lower_addr = '0;
    endcase
  end

  // --------------------------------------------------
  // Completion packing
  // --------------------------------------------------
  // No data, so length stays 0
  assign cpl_dw0 = {`UR_CPL_FMT, `UR_CPL_TYPE, tag[9], tc, tag[8], attr[2],
                    4'h0, attr[1:0], 2'b00, 10'd0};
  // BCM is never set
  assign cpl_dw1 = {completer_id, `UR_CPL_STATUS, 1'b0, byte_cnt};
  assign cpl_dw2 = {requester_id, tag[7:0], 1'b0, lower_addr};
  assign cpl_dw3 = '0;

  assign cpl_hdr = {cpl_dw3, cpl_dw2, cpl_dw1, cpl_dw0};

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  assign tx_valid_o  = req_valid_i;
  assign tx_sop_o    = req_sop_i;
  assign tx_eop_o    = req_eop_i;
  // Header bus is quiet between completions
  assign tx_header_o = req_valid_i ? cpl_hdr : '0;

endmodule

// ==== logic/ur_responder.sv ====
/*
 * Unsupported Request responder
 * Answers every non-posted request header with a UR completion
 * header one clock later. Posted packets are dropped silently.
 */
`timescale 1ns/1ps

module ur_responder (
  input  logic             clk,
  input  logic             rst_n,
  input  ur_pkg::hdr_t     rx_header_i,
  input  logic             rx_sop_i,
  input  logic             rx_eop_i,
  input  logic             rx_valid_i,
  input  ur_pkg::bus_num_t bus_num_i,
  input  ur_pkg::dev_num_t dev_num_i,
  output logic             rx_ready_o,
  output ur_pkg::hdr_t     tx_header_o,
  output logic             tx_sop_o,
  output logic             tx_eop_o,
  output logic             tx_valid_o
);

  ur_pkg::hdr_t req_hdr;
  logic         req_valid;
  logic         req_sop;
  logic         req_eop;
  logic         req_is_mem_rd;

  // Sort and register the request
  ur_rx_stage u_rx_stage (
    .clk             (clk),
    .rst_n           (rst_n),
    .rx_header_i     (rx_header_i),
    .rx_sop_i        (rx_sop_i),
    .rx_eop_i        (rx_eop_i),
    .rx_valid_i      (rx_valid_i),
    .req_hdr_o       (req_hdr),
    .req_sop_o       (req_sop),
    .req_valid_o     (req_valid),
    .req_eop_o       (req_eop),
    .req_is_mem_rd_o (req_is_mem_rd),
    .rx_ready_o      (rx_ready_o)
  );

  // Form the completion from the registered request
  ur_header_build u_header_build (
    .req_hdr_i       (req_hdr),
    .req_sop_i       (req_sop),
    .req_eop_i       (req_eop),
    .req_valid_i     (req_valid),
    .req_is_mem_rd_i (req_is_mem_rd),
    .bus_num_i       (bus_num_i),
    .dev_num_i       (dev_num_i),
    .tx_header_o     (tx_header_o),
    .tx_sop_o        (tx_sop_o),
    .tx_eop_o        (tx_eop_o),
    .tx_valid_o      (tx_valid_o)
  );

endmodule

// ==== test/ur_responder_properties.sv ====
/*
 * Assertions for the Unsupported Request responder
 * Quiet header bus while idle, a ready level that stays up and a
 * completion one cycle after every non-posted request.
 */
`timescale 1ns/1ps
`include "ur_consts.svh"

module ur_responder_props (
  input logic         clk,
  input logic         rst_n,
  input ur_pkg::hdr_t rx_header_i,
  input logic         rx_valid_i,
  input logic         rx_ready_o,
  input ur_pkg::hdr_t tx_header_o,
  input logic         tx_valid_o
);

  ur_pkg::fmt_t      fmt;
  ur_pkg::pkt_type_t typ;
  logic              posted;

  assign fmt    = rx_header_i[`UR_FMT_MSB:`UR_FMT_LSB];
  assign typ    = rx_header_i[`UR_TYPE_MSB:`UR_TYPE_LSB];
  assign posted = ((typ == `UR_TYPE_MEM) &&
                   (fmt == `UR_FMT_3DW_WR || fmt == `UR_FMT_4DW_WR)) ||
                  ((typ[4:3] == `UR_TYPE_MSG_PREFIX) &&
                   (fmt == `UR_FMT_4DW_RD || fmt == `UR_FMT_4DW_WR));

  // --------------------------------------------------
  // Properties
  // --------------------------------------------------
  a_idle_hdr_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_valid_o |-> (tx_header_o == '0))
    else $error("tx_header_o is not zero while tx_valid_o is low");

  a_ready_stays: assert property (@(posedge clk) disable iff (!rst_n)
    rx_ready_o |=> rx_ready_o)
    else $error("rx_ready_o fell while out of reset");

  a_answer_next: assert property (@(posedge clk) disable iff (!rst_n)
    (rx_valid_i && !posted) |=> tx_valid_o)
    else $error("no completion one cycle after a non-posted request");

endmodule

bind ur_responder ur_responder_props u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .rx_header_i (rx_header_i),
  .rx_valid_i  (rx_valid_i),
  .rx_ready_o  (rx_ready_o),
  .tx_header_o (tx_header_o),
  .tx_valid_o  (tx_valid_o)
);

// ==== test/ur_responder_tb.sv ====
/*
 * Testbench for the Unsupported Request responder
 * Runs reset, memory reads, posted packets, other requests and a
 * random stream through the DUT. Every output cycle is compared with
 * a reference model of the drop and completion header rules.
 */
`timescale 1ns/1ps
`include "ur_consts.svh"

module ur_responder_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  logic             clk;
  logic             rst_n;
  ur_pkg::hdr_t     rx_header_i;
  logic             rx_sop_i;
  logic             rx_eop_i;
  logic             rx_valid_i;
  ur_pkg::bus_num_t bus_num_i;
  ur_pkg::dev_num_t dev_num_i;
  logic             rx_ready_o;
  ur_pkg::hdr_t     tx_header_o;
  logic             tx_sop_o;
  logic             tx_eop_o;
  logic             tx_valid_o;

  // Requests sampled at one edge, answered at the next
  ur_pkg::hdr_t     req_q[$];
  // Strobes as {valid, sop, eop}
  logic [2:0]       strobe_q[$];
  logic             ready_exp;
  int               error_cnt;
  int               cycle_cnt;
  int               rst_cycles;

  ur_responder ur_responder_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_header_i (rx_header_i),
    .rx_sop_i    (rx_sop_i),
    .rx_eop_i    (rx_eop_i),
    .rx_valid_i  (rx_valid_i),
    .bus_num_i   (bus_num_i),
    .dev_num_i   (dev_num_i),
    .rx_ready_o  (rx_ready_o),
    .tx_header_o (tx_header_o),
    .tx_sop_o    (tx_sop_o),
    .tx_eop_o    (tx_eop_o),
    .tx_valid_o  (tx_valid_o)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Memory writes, Msg and MsgD get no answer
  function automatic logic is_posted(ur_pkg::hdr_t h);
    ur_pkg::fmt_t      fmt;
    ur_pkg::pkt_type_t typ;
    logic              mem_wr;
    logic              msg;
    fmt    = h[31:29];
    typ    = h[28:24];
    mem_wr = (typ == `UR_TYPE_MEM) && (fmt == `UR_FMT_3DW_WR || fmt == `UR_FMT_4DW_WR);
    msg    = (fmt == `UR_FMT_4DW_RD || fmt == `UR_FMT_4DW_WR) &&
             (typ[4:3] == `UR_TYPE_MSG_PREFIX);
    return mem_wr || msg;
  endfunction

  function automatic logic is_mem_read(ur_pkg::hdr_t h);
    return (h[28:24] == `UR_TYPE_MEM) &&
           (h[31:29] == `UR_FMT_3DW_RD || h[31:29] == `UR_FMT_4DW_RD);
  endfunction

  function automatic ur_pkg::hdr_t ref_completion(ur_pkg::hdr_t req, logic valid,
                                                  ur_pkg::bus_num_t bus,
                                                  ur_pkg::dev_num_t dev);
    ur_pkg::hdr_t        cpl;
    ur_pkg::tag_t        tag;
    logic [2:0]          tc;
    logic [2:0]          attr;
    ur_pkg::req_id_t     rid;
    ur_pkg::byte_cnt_t   bc;
    ur_pkg::lower_addr_t la;
    logic [31:0]         len_bytes;
    cpl = '0;
    if (!valid || is_posted(req))
      return cpl;
    tag  = {req[23], req[19], req[47:40]};
    tc   = req[22:20];
    attr = {req[18], req[13:12]};
    rid  = req[63:48];
    len_bytes = {22'd0, req[9:0]} * 32'd4;
    bc = is_mem_read(req) ? len_bytes[11:0] : `UR_DEFAULT_BYTE_CNT;
    case (req[31:24])
      8'h00:   la = {req[70:66], 2'b00};
      8'h20:   la = {req[102:98], 2'b00};
      default: la = '0;
    endcase
    // Dword 0
    cpl[31:29] = `UR_CPL_FMT;
    cpl[28:24] = `UR_CPL_TYPE;
    cpl[23]    = tag[9];
    cpl[22:20] = tc;
    cpl[19]    = tag[8];
    cpl[18]    = attr[2];
    cpl[13:12] = attr[1:0];
    // Dword 1 with function number 0
    cpl[63:56] = bus;
    cpl[55:51] = dev;
    cpl[47:45] = `UR_CPL_STATUS;
    cpl[43:32] = bc;
    // Dword 2
    cpl[95:80] = rid;
    cpl[79:72] = tag[7:0];
    cpl[70:64] = la;
    return cpl;
  endfunction

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_hdr(string name, ur_pkg::hdr_t got, ur_pkg::hdr_t exp);
    if (got !== exp)
    begin
      error_cnt++;
      stop_with_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
    begin
      error_cnt++;
      stop_with_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_reset_outputs();
    rst_cycles++;
    // First edge may come before the async reset has settled
    if (rst_cycles > 1)
    begin
      check_bit("rx_ready_o", rx_ready_o, 1'b0);
      check_bit("tx_valid_o", tx_valid_o, 1'b0);
      check_bit("tx_sop_o", tx_sop_o, 1'b0);
      check_bit("tx_eop_o", tx_eop_o, 1'b0);
      check_hdr("tx_header_o", tx_header_o, '0);
    end
    ready_exp = 1'b0;
    req_q.delete();
    strobe_q.delete();
    req_q.push_back('0);
    strobe_q.push_back(3'b000);
  endtask

  task automatic compare_cycle();
    ur_pkg::hdr_t req;
    logic [2:0]   strb;
    logic         posted;
    req    = req_q.pop_front();
    strb   = strobe_q.pop_front();
    posted = is_posted(req);
    check_hdr("tx_header_o", tx_header_o,
              ref_completion(req, strb[2], bus_num_i, dev_num_i));
    check_bit("tx_valid_o", tx_valid_o, strb[2] && !posted);
    check_bit("tx_sop_o", tx_sop_o, strb[1] && !posted);
    check_bit("tx_eop_o", tx_eop_o, strb[0] && !posted);
    check_bit("rx_ready_o", rx_ready_o, ready_exp);
    ready_exp = 1'b1;
    req_q.push_back(rx_header_i);
    strobe_q.push_back({rx_valid_i, rx_sop_i, rx_eop_i});
  endtask

  always @(posedge clk)
  begin
    if (!rst_n)
      check_reset_outputs();
    else
      compare_cycle();
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      stop_with_failure($sformatf("timeout after %0d cycles, stimulus never finished",
                                  cycle_cnt));
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic drive(ur_pkg::hdr_t h, logic sop, logic eop, logic valid);
    @(negedge clk);
    rx_header_i = h;
    rx_sop_i    = sop;
    rx_eop_i    = eop;
    rx_valid_i  = valid;
  endtask

  task automatic set_config();
    int unsigned r;
    r = $urandom;
    bus_num_i = r[7:0];
    dev_num_i = r[12:8];
  endtask

  // Random fields with a fixed format and type
  function automatic ur_pkg::hdr_t make_hdr(ur_pkg::fmt_t fmt, ur_pkg::pkt_type_t typ);
    ur_pkg::hdr_t h;
    h = {$urandom(), $urandom(), $urandom(), $urandom()};
    h[`UR_FMT_MSB:`UR_FMT_LSB]   = fmt;
    h[`UR_TYPE_MSB:`UR_TYPE_LSB] = typ;
    return h;
  endfunction

  function automatic ur_pkg::hdr_t random_hdr();
    int unsigned r;
    logic [7:0]  code;
    r = $urandom;
    case (r[2:0])
      3'd0:    code = 8'h00;
      3'd1:    code = 8'h20;
      3'd2:    code = 8'h40;
      3'd3:    code = 8'h60;
      3'd4:    code = {3'b001, 2'b10, r[5:3]};
      3'd5:    code = {3'b011, 2'b10, r[5:3]};
      default: code = r[15:8];
    endcase
    return make_hdr(code[7:5], code[4:0]);
  endfunction

  initial
  begin
    int unsigned r;
    int          i;
    logic [7:0]  other_codes [0:9];
    void'($urandom(80432));
    clk         = 1'b0;
    rst_n       = 1'b0;
    rx_header_i = '0;
    rx_sop_i    = 1'b0;
    rx_eop_i    = 1'b0;
    rx_valid_i  = 1'b0;
    bus_num_i   = 8'h3c;
    dev_num_i   = 5'h0b;
    error_cnt   = 0;
    cycle_cnt   = 0;
    rst_cycles  = 0;
    ready_exp   = 1'b0;
    // IO, config, locked reads, completions
    other_codes = '{8'h02, 8'h42, 8'h04, 8'h44, 8'h05, 8'h45, 8'h01, 8'h21, 8'h0a, 8'h4a};

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (4) drive('0, 1'b0, 1'b0, 1'b0);

    repeat (30) drive(make_hdr(`UR_FMT_3DW_RD, `UR_TYPE_MEM), 1'b1, 1'b1, 1'b1);
    repeat (30) drive(make_hdr(`UR_FMT_4DW_RD, `UR_TYPE_MEM), 1'b1, 1'b1, 1'b1);

    repeat (10)
    begin
      r = $urandom;
      drive(make_hdr(`UR_FMT_3DW_WR, `UR_TYPE_MEM), 1'b1, 1'b1, 1'b1);
      drive(make_hdr(`UR_FMT_4DW_WR, `UR_TYPE_MEM), 1'b1, 1'b1, 1'b1);
      drive(make_hdr(`UR_FMT_4DW_RD, {`UR_TYPE_MSG_PREFIX, r[2:0]}), 1'b1, 1'b1, 1'b1);
      drive(make_hdr(`UR_FMT_4DW_WR, {`UR_TYPE_MSG_PREFIX, r[5:3]}), 1'b1, 1'b1, 1'b1);
    end

    repeat (4)
    begin
      for (i = 0; i < 10; i++)
        drive(make_hdr(other_codes[i][7:5], other_codes[i][4:0]), 1'b1, 1'b1, 1'b1);
    end

    // Mixed stream with gaps while the completer ID changes now and then
    for (i = 0; i < 250; i++)
    begin
      r = $urandom;
      drive(random_hdr(), r[0], r[1], r[3:2] != 2'b00);
      if (i % 50 == 0)
        set_config();
    end

    repeat (3) drive('0, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    if (error_cnt == 0)
    begin
      $display(">>> PASS");
      $finish;
    end
    else
      stop_with_failure("checks failed during the run");
  end

endmodule

// ==== sim.f ====
+incdir+include
logic/ur_pkg.sv
logic/ur_rx_stage.sv
logic/ur_header_build.sv
logic/ur_responder.sv
test/ur_responder_properties.sv
test/ur_responder_tb.sv

// ==== Makefile ====
# Verilator build and run for the Unsupported Request responder

VERILATOR ?= verilator
TOP       ?= ur_responder_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q -F '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
